// File: hdl/cordic_fmt_pkg.sv
// cordic number formats, circular gain and arctangent table for the math cores
package cordic_fmt_pkg;

    localparam int TABLE_BITS  = 32;  // stored constants are q2.30
    localparam int TABLE_DEPTH = 32;

    // 1/k of the circular rotation, start value of x
    localparam logic [TABLE_BITS-1:0] CIRC_GAIN_INV = 32'h26dd3b6a;  // 0.6072529350

    // hyperbolic indices run twice so the vectoring converges (k = 3k+1 from 4)
    localparam int HYP_REPEAT_A = 4;
    localparam int HYP_REPEAT_B = 13;

    // atan(2^-i) in radians, q2.30
    localparam logic [TABLE_BITS-1:0] ATAN_TABLE [TABLE_DEPTH] = '{
        32'h3243f6a9, 32'h1dac6705,  // i = 0, 1
        32'h0fadbafd, 32'h07f56ea7,
        32'h03feab77, 32'h01ffd55c,
        32'h00fffaab, 32'h007fff55,
        32'h003fffeb, 32'h001ffffd,
        32'h00100000, 32'h00080000,  // from here on atan(x) ~ x
        32'h00040000, 32'h00020000,
        32'h00010000, 32'h00008000,
        32'h00004000, 32'h00002000,
        32'h00001000, 32'h00000800,
        32'h00000400, 32'h00000200,
        32'h00000100, 32'h00000080,
        32'h00000040, 32'h00000020,
        32'h00000010, 32'h00000008,
        32'h00000004, 32'h00000002,
        32'h00000001, 32'h00000000   // i = 30, 31
    };

endpackage

// File: hdl/cordic_ctrl_pkg.sv
// opcode and state encodings for the cordic control logic
package cordic_ctrl_pkg;

    // request opcodes
    typedef enum logic
    {
        OP_SQRT    = 1'b0,  // unsigned square root
        OP_COS_SIN = 1'b1   // cosine and sine of a q2.x angle
    } op_t;

    // shared by both iterative cores
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,  // waiting for start
        ST_LOAD = 2'd1,  // seed x, y (and z)
        ST_ITER = 2'd2,  // one micro-rotation per cycle
        ST_DONE = 2'd3   // result on the outputs for one cycle
    } core_state_t;

    // top level request / result sequencing
    typedef enum logic [1:0]
    {
        U_READY = 2'd0,  // free to take a request
        U_BUSY  = 2'd1,  // a core is running
        U_HOLD  = 2'd2   // result held until res_ready
    } unit_state_t;

endpackage

// File: hdl/lead_one_norm.sv
// leading-one detector that normalizes an operand by an even left shift
`timescale 1ns/1ps

module lead_one_norm #(
    parameter int DATA_WIDTH = 16
) (
    input  logic [DATA_WIDTH-1:0]         operand,
    output logic [DATA_WIDTH:0]           norm_value,  // q1.DATA_WIDTH, in [0.25, 1)
    output logic [$clog2(DATA_WIDTH)-1:0] half_shift,
    output logic                          is_zero
);

    localparam int SHW = $clog2(DATA_WIDTH);

    logic [SHW-1:0] msb_pos;     // index of the leading one
    logic [SHW-1:0] lead_gap;    // zeros above it
    logic [SHW-1:0] even_shift;

    // priority scan from lsb up so the highest set bit wins
    always_comb
    begin
        msb_pos = '0;
        for (int i = 0; i < DATA_WIDTH; i++)
        begin
            if (operand[i])
            begin
                msb_pos = SHW'(i);
            end
        end
    end

    assign lead_gap = SHW'(DATA_WIDTH - 1) - msb_pos;

    // odd gap leaves the one in the next-to-top bit
    assign even_shift = lead_gap[0] ? (lead_gap - 1'b1) : lead_gap;

    // top bit stays zero, it is headroom for the +0.25 seed
    assign norm_value = {1'b0, operand << even_shift};

    assign half_shift = even_shift >> 1;  // undone later on the root
    assign is_zero    = ~|operand;

endmodule

// File: hdl/sqrt_cordic.sv
// square-root core using hyperbolic-vectoring cordic on a normalized operand
`timescale 1ns/1ps

module sqrt_cordic #(
    parameter int DATA_WIDTH = 16,
    parameter int FRAC_WIDTH = 8,   // must be even
    parameter int SQRT_ITER  = 14
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] operand,
    output logic                  busy,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] root
);

    localparam int WORK_W  = 2 * DATA_WIDTH;  // double-width datapath
    localparam int WORK_FB = WORK_W - 2;      // q2.WORK_FB
    localparam int SHW     = $clog2(DATA_WIDTH);
    localparam int OUT_SW  = $clog2(WORK_W);
    localparam int IDX_W   = $clog2(SQRT_ITER + 1);

    // x ends as sqrt(m) in q2.WORK_FB and this shift brings it to the input q format
    localparam int ROOT_SHIFT = WORK_FB - DATA_WIDTH / 2 - FRAC_WIDTH / 2;

    // squared hyperbolic gain over all iterations and repeats in q0.30
    function automatic longint gain_sq_q30();
        longint g;
        g = longint'(1) <<< 30;
        for (int i = 1; i <= SQRT_ITER; i++)
        begin
            g = g - (g >>> (2 * i));  // times (1 - 2^-2i)
            if (i == cordic_fmt_pkg::HYP_REPEAT_A || i == cordic_fmt_pkg::HYP_REPEAT_B)
            begin
                g = g - (g >>> (2 * i));
            end
        end
        return g;
    endfunction

    localparam longint GAIN_SQ   = gain_sq_q30();
    // 0.25 / k^2 so that x ends at sqrt(m) with no gain left over
    localparam longint QUARTER_L = (longint'(1) <<< (WORK_FB - 2 + 30)) / GAIN_SQ;
    localparam logic [WORK_W-1:0] QUARTER = WORK_W'(QUARTER_L);

    cordic_ctrl_pkg::core_state_t state_r;

    logic [DATA_WIDTH-1:0]    operand_r;   // held until done for the normalizer
    logic [DATA_WIDTH:0]      norm_value;
    logic [SHW-1:0]           half_shift;
    logic                     is_zero;
    logic signed [WORK_W-1:0] norm_w;      // normalized operand in q2.WORK_FB
    logic signed [WORK_W-1:0] x_r;
    logic signed [WORK_W-1:0] y_r;
    logic signed [WORK_W-1:0] x_shr;
    logic signed [WORK_W-1:0] y_shr;
    logic [IDX_W-1:0]         idx_r;       // current index 1..SQRT_ITER
    logic                     rep_r;       // second pass of a repeat index done
    logic                     is_repeat;
    logic [OUT_SW-1:0]        out_shift;
    logic [WORK_W-1:0]        rnd_half;
    logic [WORK_W-1:0]        x_rnd;
    logic [WORK_W-1:0]        root_w;

    lead_one_norm #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_norm (
        .operand    (operand_r),
        .norm_value (norm_value),
        .half_shift (half_shift),
        .is_zero    (is_zero)
    );

    assign norm_w = {1'b0, norm_value, {(WORK_FB - DATA_WIDTH){1'b0}}};

    assign x_shr = x_r >>> idx_r;
    assign y_shr = y_r >>> idx_r;

    // first visit of index 4 or 13 stays on the same index
    assign is_repeat = (int'(idx_r) == cordic_fmt_pkg::HYP_REPEAT_A ||
                        int'(idx_r) == cordic_fmt_pkg::HYP_REPEAT_B) && !rep_r;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_r <= cordic_ctrl_pkg::ST_IDLE;
            idx_r   <= '0;
            rep_r   <= 1'b0;
        end
        else
        begin
            case (state_r)
                cordic_ctrl_pkg::ST_IDLE:
                begin
                    if (start)
                    begin
                        state_r <= cordic_ctrl_pkg::ST_LOAD;
                    end
                end
                cordic_ctrl_pkg::ST_LOAD:
                begin
                    state_r <= cordic_ctrl_pkg::ST_ITER;
                    idx_r   <= IDX_W'(1);
                    rep_r   <= 1'b0;
                end
                cordic_ctrl_pkg::ST_ITER:
                begin
                    if (is_repeat)
                    begin
                        rep_r <= 1'b1;  // run this index once more
                    end
                    else
                    begin
                        rep_r <= 1'b0;
                        if (idx_r == IDX_W'(SQRT_ITER))
                        begin
                            state_r <= cordic_ctrl_pkg::ST_DONE;
                        end
                        else
                        begin
                            idx_r <= idx_r + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state_r <= cordic_ctrl_pkg::ST_IDLE;  // done lasts one cycle
                end
            endcase
        end
    end

    // x^2 - y^2 = m is kept while y is driven to zero
    always_ff @(posedge clk)
    begin
        if (state_r == cordic_ctrl_pkg::ST_IDLE && start)
        begin
            operand_r <= operand;
        end
        if (state_r == cordic_ctrl_pkg::ST_LOAD)
        begin
            x_r <= norm_w + QUARTER;
            y_r <= norm_w - QUARTER;
        end
        else if (state_r == cordic_ctrl_pkg::ST_ITER)
        begin
            if (y_r[WORK_W-1])  // y negative
            begin
                x_r <= x_r + y_shr;
                y_r <= y_r + x_shr;
            end
            else
            begin
                x_r <= x_r - y_shr;
                y_r <= y_r - x_shr;
            end
        end
    end

    // denormalize with round to nearest
    assign out_shift = OUT_SW'(ROOT_SHIFT) + OUT_SW'(half_shift);
    assign rnd_half  = WORK_W'(1) << (out_shift - 1'b1);
    assign x_rnd     = x_r + rnd_half;
    assign root_w    = x_rnd >> out_shift;

    assign root = is_zero ? '0 : root_w[DATA_WIDTH-1:0];
    assign busy = (state_r != cordic_ctrl_pkg::ST_IDLE);
    assign done = (state_r == cordic_ctrl_pkg::ST_DONE);

endmodule

// File: hdl/rotate_cordic.sv
// circular-rotation cordic core giving cosine and sine of an angle
`timescale 1ns/1ps

module rotate_cordic #(
    parameter int DATA_WIDTH = 16,
    parameter int ROT_ITER   = 14
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] angle,    // q2.(DATA_WIDTH-2) radians
    output logic                  busy,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] cos_val,
    output logic [DATA_WIDTH-1:0] sin_val
);

    localparam int WORK_W = cordic_fmt_pkg::TABLE_BITS;  // q2.30 datapath
    localparam int PAD_W  = WORK_W - DATA_WIDTH;         // bits dropped on output
    localparam int IDX_W  = $clog2(cordic_fmt_pkg::TABLE_DEPTH);

    localparam logic [WORK_W-1:0] RND_HALF = WORK_W'(1) << (PAD_W - 1);

    cordic_ctrl_pkg::core_state_t state_r;

    logic [DATA_WIDTH-1:0]    angle_r;
    logic signed [WORK_W-1:0] x_r;   // cosine
    logic signed [WORK_W-1:0] y_r;   // sine
    logic signed [WORK_W-1:0] z_r;   // residual angle
    logic signed [WORK_W-1:0] x_shr;
    logic signed [WORK_W-1:0] y_shr;
    logic [WORK_W-1:0]        atan_val;
    logic [IDX_W-1:0]         idx_r;
    logic [WORK_W-1:0]        x_rnd;
    logic [WORK_W-1:0]        y_rnd;

    assign x_shr    = x_r >>> idx_r;
    assign y_shr    = y_r >>> idx_r;
    assign atan_val = cordic_fmt_pkg::ATAN_TABLE[idx_r];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_r <= cordic_ctrl_pkg::ST_IDLE;
            idx_r   <= '0;
        end
        else
        begin
            case (state_r)
                cordic_ctrl_pkg::ST_IDLE:
                begin
                    if (start)
                    begin
                        state_r <= cordic_ctrl_pkg::ST_LOAD;
                    end
                end
                cordic_ctrl_pkg::ST_LOAD:
                begin
                    state_r <= cordic_ctrl_pkg::ST_ITER;
                    idx_r   <= '0;
                end
                cordic_ctrl_pkg::ST_ITER:
                begin
                    if (idx_r == IDX_W'(ROT_ITER - 1))
                    begin
                        state_r <= cordic_ctrl_pkg::ST_DONE;
                    end
                    else
                    begin
                        idx_r <= idx_r + 1'b1;
                    end
                end
                default:
                begin
                    state_r <= cordic_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // rotate toward z = 0, the pre-scaled x absorbs the gain
    always_ff @(posedge clk)
    begin
        if (state_r == cordic_ctrl_pkg::ST_IDLE && start)
        begin
            angle_r <= angle;
        end
        if (state_r == cordic_ctrl_pkg::ST_LOAD)
        begin
            x_r <= cordic_fmt_pkg::CIRC_GAIN_INV;
            y_r <= '0;
            z_r <= {angle_r, {PAD_W{1'b0}}};  // widen to q2.30
        end
        else if (state_r == cordic_ctrl_pkg::ST_ITER)
        begin
            if (!z_r[WORK_W-1])  // z >= 0 so rotate counterclockwise
            begin
                x_r <= x_r - y_shr;
                y_r <= y_r + x_shr;
                z_r <= z_r - atan_val;
            end
            else
            begin
                x_r <= x_r + y_shr;
                y_r <= y_r - x_shr;
                z_r <= z_r + atan_val;
            end
        end
    end

    // round to nearest, then keep the top DATA_WIDTH bits
    assign x_rnd   = x_r + RND_HALF;
    assign y_rnd   = y_r + RND_HALF;
    assign cos_val = x_rnd[WORK_W-1 -: DATA_WIDTH];
    assign sin_val = y_rnd[WORK_W-1 -: DATA_WIDTH];

    assign busy = (state_r != cordic_ctrl_pkg::ST_IDLE);
    assign done = (state_r == cordic_ctrl_pkg::ST_DONE);

endmodule

// File: hdl/cordic_math_unit.sv
// cordic math unit top, routes sqrt and cos/sin requests and holds the result
`timescale 1ns/1ps

module cordic_math_unit #(
    parameter int DATA_WIDTH = 16,
    parameter int FRAC_WIDTH = 8,
    parameter int SQRT_ITER  = 14,
    parameter int ROT_ITER   = 14
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      op_valid,
    output logic                      op_ready,
    input  cordic_ctrl_pkg::op_t      op_code,
    input  logic [DATA_WIDTH-1:0]     op_data,
    output logic                      res_valid,
    input  logic                      res_ready,
    output logic [2*DATA_WIDTH-1:0]   res_data
);

    cordic_ctrl_pkg::unit_state_t state_r;
    cordic_ctrl_pkg::unit_state_t state_nxt;
    cordic_ctrl_pkg::op_t         active_op;  // opcode of the running request

    logic                    ready_r;    // low through reset and while busy or holding
    logic                    path_busy;
    logic                    accept;
    logic                    sqrt_start;
    logic                    sqrt_busy;
    logic                    sqrt_done;
    logic [DATA_WIDTH-1:0]   sqrt_root;
    logic                    rot_start;
    logic                    rot_busy;
    logic                    rot_done;
    logic [DATA_WIDTH-1:0]   rot_cos;
    logic [DATA_WIDTH-1:0]   rot_sin;
    logic                    fin_done;
    logic [2*DATA_WIDTH-1:0] fin_data;

    // selected core must also be idle
    assign path_busy = (op_code == cordic_ctrl_pkg::OP_SQRT) ? sqrt_busy : rot_busy;
    assign op_ready  = ready_r && !path_busy;
    assign accept    = op_valid && op_ready;

    assign sqrt_start = accept && (op_code == cordic_ctrl_pkg::OP_SQRT);
    assign rot_start  = accept && (op_code == cordic_ctrl_pkg::OP_COS_SIN);

    sqrt_cordic #(
        .DATA_WIDTH (DATA_WIDTH),
        .FRAC_WIDTH (FRAC_WIDTH),
        .SQRT_ITER  (SQRT_ITER)
    ) u_sqrt (
        .clk     (clk),
        .rst     (rst),
        .start   (sqrt_start),
        .operand (op_data),
        .busy    (sqrt_busy),
        .done    (sqrt_done),
        .root    (sqrt_root)
    );

    rotate_cordic #(
        .DATA_WIDTH (DATA_WIDTH),
        .ROT_ITER   (ROT_ITER)
    ) u_rot (
        .clk     (clk),
        .rst     (rst),
        .start   (rot_start),
        .angle   (op_data),
        .busy    (rot_busy),
        .done    (rot_done),
        .cos_val (rot_cos),
        .sin_val (rot_sin)
    );

    // sqrt keeps the high half zero, cos/sin packs sine on top
    assign fin_done = (active_op == cordic_ctrl_pkg::OP_SQRT) ? sqrt_done : rot_done;
    assign fin_data = (active_op == cordic_ctrl_pkg::OP_SQRT) ?
                      {{DATA_WIDTH{1'b0}}, sqrt_root} : {rot_sin, rot_cos};

    always_comb
    begin
        state_nxt = state_r;
        case (state_r)
            cordic_ctrl_pkg::U_READY: if (accept)    state_nxt = cordic_ctrl_pkg::U_BUSY;
            cordic_ctrl_pkg::U_BUSY:  if (fin_done)  state_nxt = cordic_ctrl_pkg::U_HOLD;
            cordic_ctrl_pkg::U_HOLD:  if (res_ready) state_nxt = cordic_ctrl_pkg::U_READY;
            default:                  state_nxt = cordic_ctrl_pkg::U_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_r   <= cordic_ctrl_pkg::U_READY;
            ready_r   <= 1'b0;
            active_op <= cordic_ctrl_pkg::OP_SQRT;
        end
        else
        begin
            state_r <= state_nxt;
            ready_r <= (state_nxt == cordic_ctrl_pkg::U_READY);
            if (accept)
            begin
                active_op <= op_code;
            end
        end
    end

    // result register only loads on done, stays put under back-pressure
    always_ff @(posedge clk)
    begin
        if (state_r == cordic_ctrl_pkg::U_BUSY && fin_done)
        begin
            res_data <= fin_data;
        end
    end

    assign res_valid = (state_r == cordic_ctrl_pkg::U_HOLD);

endmodule

// File: verification/tb_cordic_math_unit.sv
// directed testbench that checks sqrt and cos/sin of the cordic math unit against real-number models
`timescale 1ns/1ps

module tb_cordic_math_unit;

    localparam int  DATA_WIDTH   = 16;
    localparam int  FRAC_WIDTH   = 8;
    localparam int  ANG_FB       = DATA_WIDTH - 2;  // q2.14 angles and results
    localparam int  HALF_PI_CODE = 25735;           // floor(pi/2 * 2^14)
    localparam int  MAX_STALL    = 20;
    localparam int  NUM_REQ      = 101;             // 6 + 40 + 37 + 6 + 12 requests
    localparam int  CYCLE_LIMIT  = NUM_REQ * (18 + MAX_STALL + 4) * 2;
    localparam int  MIXED_REQ    = 12;
    localparam real PI           = 3.14159265358979;

    logic                    clk;
    logic                    rst;
    logic                    op_valid;
    logic                    op_ready;
    cordic_ctrl_pkg::op_t    op_code;
    logic [DATA_WIDTH-1:0]   op_data;
    logic                    res_valid;
    logic                    res_ready;
    logic [2*DATA_WIDTH-1:0] res_data;

    int    cycle_count;
    int    check_count;
    int    err_count;
    int    errs_at_start;  // err_count when the current test began
    string test_name;

    cordic_ctrl_pkg::op_t  exp_op_q[$];    // accepted requests not yet answered
    logic [DATA_WIDTH-1:0] exp_data_q[$];

    cordic_math_unit uut (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_code   (op_code),
        .op_data   (op_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // stops a hung run after the worst-case cycle count
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    // ideal root in the same q format as the operand
    function automatic real sqrt_model(input logic [DATA_WIDTH-1:0] operand);
        real scale;
        scale = 2.0 ** FRAC_WIDTH;
        return $sqrt(operand / scale) * scale;
    endfunction

    function automatic real angle_to_rad(input logic [DATA_WIDTH-1:0] code);
        return $itor($signed(code)) / (2.0 ** ANG_FB);
    endfunction

    function automatic real cos_model(input logic [DATA_WIDTH-1:0] code);
        return $cos(angle_to_rad(code)) * (2.0 ** ANG_FB);
    endfunction

    function automatic real sin_model(input logic [DATA_WIDTH-1:0] code);
        return $sin(angle_to_rad(code)) * (2.0 ** ANG_FB);
    endfunction

    // radians to a q2.14 code truncated toward zero so pi/2 stays in range
    function automatic logic [DATA_WIDTH-1:0] angle_code(input real rad);
        return DATA_WIDTH'($rtoi(rad * (2.0 ** ANG_FB)));
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_angle();
        int a;
        a = int'($urandom_range(0, 2 * HALF_PI_CODE)) - HALF_PI_CODE;
        return DATA_WIDTH'(a);
    endfunction

    task automatic check_value(input real expected, input int actual, input real tol);
        check_count++;
        assert ((actual - expected) <= tol && (expected - actual) <= tol)
        else
        begin
            $display("ERR %s expected %0.3f actual %0d", test_name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic cond, input string what);
        check_count++;
        assert (cond)
        else
        begin
            $display("%s: %s", test_name, what);
            err_count++;
        end
    endtask

    task automatic check_result(input cordic_ctrl_pkg::op_t op,
                                input logic [DATA_WIDTH-1:0] data,
                                input logic [2*DATA_WIDTH-1:0] result);
        if (op == cordic_ctrl_pkg::OP_SQRT)
        begin
            check_value(sqrt_model(data), int'(result[DATA_WIDTH-1:0]), 2.0);
            check_value(0.0, int'(result[2*DATA_WIDTH-1:DATA_WIDTH]), 0.0);  // high half unused
        end
        else
        begin
            check_value(cos_model(data), int'($signed(result[DATA_WIDTH-1:0])), 4.0);
            check_value(sin_model(data), int'($signed(result[2*DATA_WIDTH-1:DATA_WIDTH])), 4.0);
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        $display("%s finished, %0d errors", test_name, err_count - errs_at_start);
    endtask

    // holds op_valid until the handshake edge
    task automatic send_request(input cordic_ctrl_pkg::op_t op, input logic [DATA_WIDTH-1:0] data);
        @(posedge clk);
        op_code  <= op;
        op_data  <= data;
        op_valid <= 1'b1;
        @(negedge clk);
        while (!op_ready) @(negedge clk);
        @(posedge clk);  // request taken here
        op_valid <= 1'b0;
    endtask

    // waits for res_valid, stalls res_ready, then takes the result
    task automatic take_result(input int stall, output logic [2*DATA_WIDTH-1:0] data);
        logic [2*DATA_WIDTH-1:0] held;
        @(negedge clk);
        while (!res_valid) @(negedge clk);
        held = res_data;
        for (int i = 0; i < stall; i++)
        begin
            @(negedge clk);
            check_flag(res_valid && res_data == held, "result changed or dropped while stalled");
            check_flag(!op_ready, "op_ready high while a result is held");
        end
        @(posedge clk);
        res_ready <= 1'b1;
        @(negedge clk);
        check_flag(res_valid && res_data == held, "result changed before the handshake");
        data = res_data;
        @(posedge clk);  // result taken here
        res_ready <= 1'b0;
    endtask

    task automatic run_op(input cordic_ctrl_pkg::op_t op, input logic [DATA_WIDTH-1:0] data,
                          input int stall);
        logic [2*DATA_WIDTH-1:0] result;
        send_request(op, data);
        take_result(stall, result);
        check_result(op, data, result);
    endtask

    task automatic test_reset();
        begin_test("reset");
        @(negedge clk);  // reset still sampled high on the last edge
        check_flag(!res_valid && !op_ready, "res_valid or op_ready high in reset");
        @(negedge clk);
        check_flag(op_ready && !res_valid, "op_ready not high one cycle after reset");
        end_test();
    endtask

    task automatic test_sqrt_directed();
        logic [DATA_WIDTH-1:0] ops [6] = '{16'h0000, 16'h0100, 16'h0400, 16'h1000,
                                           16'h0040, 16'hffff};  // 0, 1, 4, 16, 0.25, max
        begin_test("sqrt_directed");
        foreach (ops[i])
        begin
            run_op(cordic_ctrl_pkg::OP_SQRT, ops[i], 0);
        end
        end_test();
    endtask

    task automatic test_sqrt_random();
        begin_test("sqrt_random");
        repeat (40)
        begin
            run_op(cordic_ctrl_pkg::OP_SQRT, DATA_WIDTH'($urandom_range(1, 65535)), 0);
        end
        end_test();
    endtask

    task automatic test_cos_sin();
        real angles [7] = '{0.0, PI / 6.0, -PI / 6.0, PI / 4.0, -PI / 4.0, PI / 2.0, -PI / 2.0};
        begin_test("cos_sin");
        foreach (angles[i])
        begin
            run_op(cordic_ctrl_pkg::OP_COS_SIN, angle_code(angles[i]), 0);
        end
        repeat (30)
        begin
            run_op(cordic_ctrl_pkg::OP_COS_SIN, random_angle(), 0);
        end
        end_test();
    endtask

    task automatic test_backpressure();
        begin_test("backpressure");
        for (int i = 0; i < 6; i++)
        begin
            if (i % 2 == 0)
            begin
                run_op(cordic_ctrl_pkg::OP_SQRT, DATA_WIDTH'($urandom_range(0, 65535)),
                       int'($urandom_range(1, MAX_STALL)));
            end
            else
            begin
                run_op(cordic_ctrl_pkg::OP_COS_SIN, random_angle(),
                       int'($urandom_range(1, MAX_STALL)));
            end
        end
        end_test();
    endtask

    // op_valid stays high while requests are queued at each handshake and matched in order
    task automatic test_mixed();
        cordic_ctrl_pkg::op_t op;
        logic [DATA_WIDTH-1:0] data;
        logic                  extra;
        begin_test("mixed");
        fork
            begin
                @(posedge clk);
                op_valid <= 1'b1;
                for (int i = 0; i < MIXED_REQ; i++)
                begin
                    op_code <= (i % 2 == 0) ? cordic_ctrl_pkg::OP_SQRT
                                            : cordic_ctrl_pkg::OP_COS_SIN;
                    op_data <= (i % 2 == 0) ? DATA_WIDTH'($urandom_range(0, 65535))
                                            : random_angle();
                    @(negedge clk);
                    while (!op_ready) @(negedge clk);
                    exp_op_q.push_back(op_code);
                    exp_data_q.push_back(op_data);
                    @(posedge clk);  // accepted on this edge and the next request goes out
                end
                op_valid <= 1'b0;
            end
            begin
                @(posedge clk);
                res_ready <= 1'b1;
                for (int n = 0; n < MIXED_REQ; n++)
                begin
                    @(negedge clk);
                    while (!res_valid) @(negedge clk);
                    if (exp_op_q.size() == 0)
                    begin
                        check_flag(1'b0, "result arrived with no accepted request");
                    end
                    else
                    begin
                        op   = exp_op_q.pop_front();
                        data = exp_data_q.pop_front();
                        check_result(op, data, res_data);
                    end
                    @(posedge clk);
                end
                res_ready <= 1'b0;
            end
        join
        extra = 1'b0;
        repeat (25)
        begin
            @(negedge clk);
            extra = extra | res_valid;  // nothing more may come out
        end
        check_flag(!extra && exp_op_q.size() == 0, "result count differs from accepted requests");
        end_test();
    endtask

    initial
    begin
        rst         = 1'b1;
        op_valid    = 1'b0;
        op_code     = cordic_ctrl_pkg::OP_SQRT;
        op_data     = '0;
        res_ready   = 1'b0;
        check_count = 0;
        err_count   = 0;
        void'($urandom(64));
        for (int i = 0; i < cordic_fmt_pkg::TABLE_DEPTH; i++)
        begin
            $display("atan table %0d: %h", i, cordic_fmt_pkg::ATAN_TABLE[i]);
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_sqrt_directed();
        test_sqrt_random();
        test_cos_sin();
        test_backpressure();
        test_mixed();
        $display("tests 6, checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/cordic_fmt_pkg.sv
hdl/cordic_ctrl_pkg.sv
hdl/lead_one_norm.sv
hdl/sqrt_cordic.sv
hdl/rotate_cordic.sv
hdl/cordic_math_unit.sv
verification/tb_cordic_math_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cordic math unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_cordic_math_unit -f files.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
